// ==== hw/spi_consts.svh ====
/* Widths, register map and reset values of the SPI master.
   Included by the package and by every block that sizes ports from it. */
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// Datapath and host address widths
`define SPI_DATA_W       32
`define SPI_ADDR_W       8
`define SPI_NUM_SS       4
`define SPI_FIFO_DEPTH   16

// Register offsets, word aligned
`define SPI_REG_ID       8'h00
`define SPI_REG_RESET    8'h10
`define SPI_REG_CTRL     8'h20
`define SPI_REG_STATUS   8'h28
`define SPI_REG_SS       8'h2C
`define SPI_REG_TX       8'h30
`define SPI_REG_RX       8'h34

`define SPI_ID_VALUE     32'h294EC100
`define SPI_RESET_KEY    32'h0000000A
`define SPI_DEF_PRESCALE 16'd4
`define SPI_DEF_WIDTH    8'd8

`endif

// ==== hw/spi_pkg.sv ====
/* Types shared by the SPI master blocks and its testbench.
   Host request structs and the decoded control register. */
`default_nettype none

`include "spi_consts.svh"

package spi_pkg;

    // Control register fields
    typedef struct packed {
        logic [15:0] prescale;
        logic [7:0]  word_width;
        logic        mssa;
        logic        lsb_first;
        logic        cpol;
        logic        cpha;
        logic        spe;
        logic        loop;
    } spi_cfg_t;

    // Host write, address and data travel together
    typedef struct packed {
        logic [`SPI_ADDR_W-1:0] addr;
        logic [`SPI_DATA_W-1:0] data;
    } axil_wr_t;

    typedef struct packed {
        logic [`SPI_ADDR_W-1:0] addr;
    } axil_rd_t;

endpackage

`default_nettype wire

// ==== hw/spi_fifo.sv ====
/* Synchronous word FIFO with valid/ready on both sides.
   Serves as both the transmit and the receive queue. */
`default_nettype none

`include "spi_consts.svh"

module spi_fifo #(
    parameter int DEPTH = `SPI_FIFO_DEPTH
) (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    clear_i,
    input  wire  [`SPI_DATA_W-1:0] in_data_i,
    input  wire                    in_valid_i,
    output logic                   in_ready_o,
    output logic [`SPI_DATA_W-1:0] out_data_o,
    output logic                   out_valid_o,
    input  wire                    out_ready_i
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [`SPI_DATA_W-1:0] mem [DEPTH];
    logic [PTR_W-1:0]       wr_ptr_q;
    logic [PTR_W-1:0]       rd_ptr_q;
    logic [PTR_W:0]         count_q;
    logic                   push;
    logic                   pop;

    // Full and empty show up as the handshake signals
    assign in_ready_o  = (count_q != (PTR_W + 1)'(DEPTH));
    assign out_valid_o = (count_q != '0);
    assign out_data_o  = mem[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr_q] <= in_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/spi_regs.sv ====
/* Host register block of the SPI master on a reduced AXI-lite port.
   Holds control and slave select, feeds the TX FIFO and drains the RX FIFO. */
`default_nettype none

`include "spi_consts.svh"

module spi_regs (
    input  wire                         clk,
    input  wire                         reset_i,
    input  wire spi_pkg::axil_wr_t      wr_req_i,
    input  wire                         wr_valid_i,
    output logic                        wr_ready_o,
    output logic                        b_valid_o,
    input  wire                         b_ready_i,
    input  wire spi_pkg::axil_rd_t      rd_req_i,
    input  wire                         rd_valid_i,
    output logic                        rd_ready_o,
    output logic [`SPI_DATA_W-1:0]      r_data_o,
    output logic                        r_valid_o,
    input  wire                         r_ready_i,
    output logic [`SPI_DATA_W-1:0]      tx_data_o,
    output logic                        tx_valid_o,
    input  wire                         tx_ready_i,
    input  wire  [`SPI_DATA_W-1:0]      rx_data_i,
    input  wire                         rx_valid_i,
    output logic                        rx_ready_o,
    input  wire                         tx_empty_i,
    input  wire                         rx_full_i,
    output spi_pkg::spi_cfg_t           cfg_o,
    output logic [`SPI_NUM_SS-1:0]      ss_o,
    output logic                        clear_o
);

    // A width field of 0 stands for the default word width
    localparam spi_pkg::spi_cfg_t CFG_DEFAULT = '{
        prescale:   `SPI_DEF_PRESCALE,
        word_width: 8'd0,
        mssa:       1'b1,
        default:    1'b0
    };

    spi_pkg::spi_cfg_t      cfg_q;
    logic [`SPI_NUM_SS-1:0] ss_q;
    logic                   do_wr;
    logic                   do_rd;
    logic [`SPI_ADDR_W-1:0] wr_addr;
    logic [`SPI_ADDR_W-1:0] rd_addr;
    logic [`SPI_DATA_W-1:0] rd_word;

    assign do_wr   = wr_valid_i && wr_ready_o;
    assign do_rd   = rd_valid_i && rd_ready_o;
    assign wr_addr = {wr_req_i.addr[`SPI_ADDR_W-1:2], 2'b00};
    assign rd_addr = {rd_req_i.addr[`SPI_ADDR_W-1:2], 2'b00};

    // Host handshakes, ready pulses once and waits for the response to drain
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ready_o <= 1'b0;
            b_valid_o  <= 1'b0;
            rd_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
        end else begin
            wr_ready_o <= wr_valid_i && !wr_ready_o && !(b_valid_o && !b_ready_i);
            b_valid_o  <= do_wr || (b_valid_o && !b_ready_i);
            rd_ready_o <= rd_valid_i && !rd_ready_o && !(r_valid_o && !r_ready_i);
            r_valid_o  <= do_rd || (r_valid_o && !r_ready_i);
        end
    end

    // Register writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            cfg_q   <= CFG_DEFAULT;
            ss_q    <= '1;
            clear_o <= 1'b0;
        end else begin
            clear_o <= 1'b0;
            if (do_wr) begin
                case (wr_addr)
                    `SPI_REG_RESET: begin
                        if (wr_req_i.data == `SPI_RESET_KEY) begin
                            cfg_q   <= CFG_DEFAULT;
                            ss_q    <= '1;
                            clear_o <= 1'b1;
                        end
                    end
                    `SPI_REG_CTRL: begin
                        cfg_q.prescale   <= wr_req_i.data[31:16];
                        cfg_q.word_width <= wr_req_i.data[15:8];
                        cfg_q.mssa       <= wr_req_i.data[5];
                        cfg_q.lsb_first  <= wr_req_i.data[4];
                        cfg_q.cpol       <= wr_req_i.data[3];
                        cfg_q.cpha       <= wr_req_i.data[2];
                        cfg_q.spe        <= wr_req_i.data[1];
                        cfg_q.loop       <= wr_req_i.data[0];
                        // Any new configuration flushes both queues
                        clear_o          <= 1'b1;
                    end
                    `SPI_REG_SS: ss_q <= wr_req_i.data[`SPI_NUM_SS-1:0];
                    default: ;
                endcase
            end
        end
    end

    // TX push lasts the handshake cycle only, so a full FIFO drops the word
    assign tx_valid_o = do_wr && (wr_addr == `SPI_REG_TX);
    assign tx_data_o  = wr_req_i.data;

    assign rx_ready_o = do_rd && (rd_addr == `SPI_REG_RX);

    always_comb begin
        rd_word = '0;
        case (rd_addr)
            `SPI_REG_ID:     rd_word = `SPI_ID_VALUE;
            `SPI_REG_CTRL: begin
                rd_word = {cfg_q.prescale, cfg_q.word_width, 2'b00,
                           cfg_q.mssa, cfg_q.lsb_first, cfg_q.cpol,
                           cfg_q.cpha, cfg_q.spe, cfg_q.loop};
            end
            // TX_FULL, TX_EMPTY, RX_FULL, RX_EMPTY
            `SPI_REG_STATUS: rd_word[3:0] = {~tx_ready_i, tx_empty_i, rx_full_i, ~rx_valid_i};
            `SPI_REG_SS:     rd_word[`SPI_NUM_SS-1:0] = ss_q;
            `SPI_REG_RX: begin
                if (rx_valid_i) begin
                    rd_word = rx_data_i;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (do_rd) begin
            r_data_o <= rd_word;
        end
    end

    always_comb begin
        cfg_o = cfg_q;
        if (cfg_q.word_width == 8'd0) begin
            cfg_o.word_width = `SPI_DEF_WIDTH;
        end
    end

    assign ss_o = ss_q;

endmodule

`default_nettype wire

// ==== hw/spi_engine.sv ====
/* SPI serial engine, one word per transfer in any of the four modes.
   Pops the TX FIFO, drives SCLK and MOSI, and pushes the received word. */
`default_nettype none

`include "spi_consts.svh"

module spi_engine (
    input  wire                    clk,
    input  wire                    reset_i,
    input  wire                    clear_i,
    input  wire spi_pkg::spi_cfg_t cfg_i,
    input  wire  [`SPI_DATA_W-1:0] tx_data_i,
    input  wire                    tx_valid_i,
    output logic                   tx_ready_o,
    output logic [`SPI_DATA_W-1:0] rx_data_o,
    output logic                   rx_valid_o,
    input  wire                    rx_ready_i,
    input  wire                    miso_i,
    output logic                   sclk_o,
    output logic                   mosi_o,
    output logic                   busy_o
);

    logic                   busy_q;
    logic                   rx_valid_q;
    logic                   sclk_q;
    logic                   mosi_q;
    logic [15:0]            pcnt_q;
    logic [5:0]             hcnt_q;
    logic [`SPI_DATA_W-1:0] tx_q;
    logic [`SPI_DATA_W-1:0] rx_q;
    logic [4:0]             wm1;
    logic [4:0]             bit_idx;
    logic [4:0]             next_idx;
    logic [4:0]             first_idx;
    logic                   start;
    logic                   edge_tick;
    logic                   leading;
    logic                   last_edge;

    // Word width minus one, widths above 32 clamp to 32
    assign wm1 = (cfg_i.word_width > 8'd32) ? 5'd31 : 5'(cfg_i.word_width - 8'd1);

    // Hold off new words while the RX FIFO has no room for the result
    assign tx_ready_o = cfg_i.spe && rx_ready_i && !busy_q;
    assign start      = tx_valid_i && tx_ready_o;

    // hcnt counts SCLK edges, even ones lead and odd ones trail
    assign edge_tick = busy_q && !rx_valid_q && (pcnt_q == cfg_i.prescale);
    assign leading   = !hcnt_q[0];
    assign last_edge = hcnt_q[0] && (hcnt_q[5:1] == wm1);

    // Bit positions inside the right-aligned word
    assign first_idx = cfg_i.lsb_first ? 5'd0 : wm1;
    assign bit_idx   = cfg_i.lsb_first ? hcnt_q[5:1] : wm1 - hcnt_q[5:1];
    assign next_idx  = cfg_i.lsb_first ? hcnt_q[5:1] + 5'd1 : wm1 - hcnt_q[5:1] - 5'd1;

    always_ff @(posedge clk) begin
        if (reset_i || clear_i) begin
            busy_q     <= 1'b0;
            rx_valid_q <= 1'b0;
            sclk_q     <= 1'b0;
            mosi_q     <= 1'b0;
            pcnt_q     <= '0;
            hcnt_q     <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            sclk_q <= cfg_i.cpol;
            pcnt_q <= '0;
            hcnt_q <= '0;
            // CPHA 0 puts the first bit out before the leading edge
            if (!cfg_i.cpha) begin
                mosi_q <= tx_data_i[first_idx];
            end
        end else if (rx_valid_q) begin
            rx_valid_q <= 1'b0;
            busy_q     <= 1'b0;
        end else if (busy_q) begin
            if (edge_tick) begin
                pcnt_q <= '0;
                sclk_q <= ~sclk_q;
                hcnt_q <= hcnt_q + 6'd1;
                if (leading && cfg_i.cpha) begin
                    mosi_q <= tx_q[bit_idx];
                end
                if (!leading && !cfg_i.cpha && !last_edge) begin
                    mosi_q <= tx_q[next_idx];
                end
                if (last_edge) begin
                    rx_valid_q <= 1'b1;
                end
            end else begin
                pcnt_q <= pcnt_q + 16'd1;
            end
        end
    end

    // Sample on leading edges for CPHA 0, trailing edges for CPHA 1
    always_ff @(posedge clk) begin
        if (start) begin
            tx_q <= tx_data_i;
            rx_q <= '0;
        end else if (edge_tick && (leading != cfg_i.cpha)) begin
            rx_q[bit_idx] <= miso_i;
        end
    end

    assign sclk_o     = busy_q ? sclk_q : cfg_i.cpol;
    assign mosi_o     = mosi_q;
    assign rx_data_o  = rx_q;
    assign rx_valid_o = rx_valid_q;
    assign busy_o     = busy_q;

endmodule

`default_nettype wire

// ==== hw/spi_axil_top.sv ====
/* Top level of the SPI master with its host register port.
   Connects registers, FIFOs and engine, and decodes the slave selects. */
`default_nettype none

`include "spi_consts.svh"

module spi_axil_top (
    input  wire                         clk,
    input  wire                         reset_i,
    input  wire spi_pkg::axil_wr_t      wr_req_i,
    input  wire                         wr_valid_i,
    output logic                        wr_ready_o,
    output logic                        b_valid_o,
    input  wire                         b_ready_i,
    input  wire spi_pkg::axil_rd_t      rd_req_i,
    input  wire                         rd_valid_i,
    output logic                        rd_ready_o,
    output logic [`SPI_DATA_W-1:0]      r_data_o,
    output logic                        r_valid_o,
    input  wire                         r_ready_i,
    output logic                        spi_sclk_o,
    output logic                        spi_mosi_o,
    input  wire                         spi_miso_i,
    output logic [`SPI_NUM_SS-1:0]      spi_ncs_o
);

    spi_pkg::spi_cfg_t      cfg;
    logic [`SPI_NUM_SS-1:0] ss;
    logic [`SPI_NUM_SS-1:0] ncs;
    logic                   clear;
    logic [`SPI_DATA_W-1:0] tx_push_data;
    logic                   tx_push_valid;
    logic                   tx_push_ready;
    logic [`SPI_DATA_W-1:0] tx_pop_data;
    logic                   tx_pop_valid;
    logic                   tx_pop_ready;
    logic [`SPI_DATA_W-1:0] rx_push_data;
    logic                   rx_push_valid;
    logic                   rx_push_ready;
    logic [`SPI_DATA_W-1:0] rx_pop_data;
    logic                   rx_pop_valid;
    logic                   rx_pop_ready;
    logic                   busy;
    logic                   sclk;
    logic                   mosi;
    logic                   miso;

    spi_regs u_regs (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_req_i   (wr_req_i),
        .wr_valid_i (wr_valid_i),
        .wr_ready_o (wr_ready_o),
        .b_valid_o  (b_valid_o),
        .b_ready_i  (b_ready_i),
        .rd_req_i   (rd_req_i),
        .rd_valid_i (rd_valid_i),
        .rd_ready_o (rd_ready_o),
        .r_data_o   (r_data_o),
        .r_valid_o  (r_valid_o),
        .r_ready_i  (r_ready_i),
        .tx_data_o  (tx_push_data),
        .tx_valid_o (tx_push_valid),
        .tx_ready_i (tx_push_ready),
        .rx_data_i  (rx_pop_data),
        .rx_valid_i (rx_pop_valid),
        .rx_ready_o (rx_pop_ready),
        .tx_empty_i (~tx_pop_valid),
        .rx_full_i  (~rx_push_ready),
        .cfg_o      (cfg),
        .ss_o       (ss),
        .clear_o    (clear)
    );

    spi_fifo #(.DEPTH(`SPI_FIFO_DEPTH)) u_tx_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .clear_i     (clear),
        .in_data_i   (tx_push_data),
        .in_valid_i  (tx_push_valid),
        .in_ready_o  (tx_push_ready),
        .out_data_o  (tx_pop_data),
        .out_valid_o (tx_pop_valid),
        .out_ready_i (tx_pop_ready)
    );

    spi_fifo #(.DEPTH(`SPI_FIFO_DEPTH)) u_rx_fifo (
        .clk         (clk),
        .reset_i     (reset_i),
        .clear_i     (clear),
        .in_data_i   (rx_push_data),
        .in_valid_i  (rx_push_valid),
        .in_ready_o  (rx_push_ready),
        .out_data_o  (rx_pop_data),
        .out_valid_o (rx_pop_valid),
        .out_ready_i (rx_pop_ready)
    );

    spi_engine u_engine (
        .clk        (clk),
        .reset_i    (reset_i),
        .clear_i    (clear),
        .cfg_i      (cfg),
        .tx_data_i  (tx_pop_data),
        .tx_valid_i (tx_pop_valid),
        .tx_ready_o (tx_pop_ready),
        .rx_data_o  (rx_push_data),
        .rx_valid_o (rx_push_valid),
        .rx_ready_i (rx_push_ready),
        .miso_i     (miso),
        .sclk_o     (sclk),
        .mosi_o     (mosi),
        .busy_o     (busy)
    );

    // Highest low bit of the select register wins
    always_comb begin
        ncs = '1;
        for (int i = 0; i < `SPI_NUM_SS; i++) begin
            if (!ss[i]) begin
                ncs    = '1;
                ncs[i] = cfg.mssa ? 1'b0 : ~busy;
            end
        end
    end

    // Bus held idle while disabled
    assign spi_sclk_o = cfg.spe ? sclk : 1'b0;
    assign spi_mosi_o = cfg.spe ? mosi : 1'b0;
    assign spi_ncs_o  = cfg.spe ? ncs : '1;

    assign miso = cfg.spe ? (cfg.loop ? spi_mosi_o : spi_miso_i) : 1'b0;

endmodule

`default_nettype wire

// ==== dv/tb_spi.sv ====
/* Self-checking testbench for the SPI master with its host register port.
   Covers loopback, all SPI modes against a slave model, gating and reset. */
`default_nettype none

`include "spi_consts.svh"

module tb_spi;

    localparam int PERIOD     = 40;
    localparam int LOOP_WORDS = 4;
    localparam int NUM_MODES  = 8;
    // Each word at most 32 bits of 4 cycles, plus host polling and margin
    localparam int WATCHDOG   = 2 * (LOOP_WORDS + NUM_MODES) * (4 * 32 + 60) * PERIOD + 20000;

    logic                   clk;
    logic                   reset_i;
    spi_pkg::axil_wr_t      wr_req;
    logic                   wr_valid_i;
    logic                   wr_ready_o;
    logic                   b_valid_o;
    logic                   b_ready_i;
    spi_pkg::axil_rd_t      rd_req;
    logic                   rd_valid_i;
    logic                   rd_ready_o;
    logic [`SPI_DATA_W-1:0] r_data_o;
    logic                   r_valid_o;
    logic                   r_ready_i;
    logic                   spi_sclk_o;
    logic                   spi_mosi_o;
    logic                   spi_miso_i;
    logic [`SPI_NUM_SS-1:0] spi_ncs_o;

    int                     errors;
    logic [31:0]            rand_state;
    logic [`SPI_NUM_SS-1:0] sel_mask;
    logic                   spe_off;
    // Slave model state
    logic                   slave_on;
    logic                   m_cpol;
    logic                   m_cpha;
    logic                   m_lsb;
    int                     m_width;
    int                     edge_k;
    logic [31:0]            slave_tx;
    logic [31:0]            slave_rx;

    spi_axil_top dut_i (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_req_i   (wr_req),
        .wr_valid_i (wr_valid_i),
        .wr_ready_o (wr_ready_o),
        .b_valid_o  (b_valid_o),
        .b_ready_i  (b_ready_i),
        .rd_req_i   (rd_req),
        .rd_valid_i (rd_valid_i),
        .rd_ready_o (rd_ready_o),
        .r_data_o   (r_data_o),
        .r_valid_o  (r_valid_o),
        .r_ready_i  (r_ready_i),
        .spi_sclk_o (spi_sclk_o),
        .spi_mosi_o (spi_mosi_o),
        .spi_miso_i (spi_miso_i),
        .spi_ncs_o  (spi_ncs_o)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #WATCHDOG;
        $display("Watchdog expired after %0d time units, the run did not finish", WATCHDOG);
        $display("TEST FAIL");
        $finish;
    end

    // Disabled bus stays idle
    assert property (@(posedge clk) disable iff (reset_i)
        spe_off |-> (&spi_ncs_o && !spi_sclk_o))
    else begin
        $display("FAILED %0t: SPI outputs active while disabled", $time);
        errors++;
    end

    // Only the decoded select line may ever go low
    assert property (@(posedge clk) disable iff (reset_i) &(spi_ncs_o | sel_mask))
    else begin
        $display("FAILED %0t: ncs 0x%h outside select 0x%h", $time, spi_ncs_o, sel_mask);
        errors++;
    end

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic logic [31:0] width_mask(input int width);
        logic [63:0] m;
        m = (64'd1 << width) - 64'd1;
        return m[31:0];
    endfunction

    function automatic int bit_pos(input int k);
        return m_lsb ? k : m_width - 1 - k;
    endfunction

    // Highest low bit of the select register wins
    function automatic logic [`SPI_NUM_SS-1:0] active_select(input logic [`SPI_NUM_SS-1:0] ss);
        logic [`SPI_NUM_SS-1:0] mask;
        mask = '0;
        for (int i = 0; i < `SPI_NUM_SS; i++) begin
            if (!ss[i]) begin
                mask = `SPI_NUM_SS'(1 << i);
            end
        end
        return mask;
    endfunction

    // Flags are mssa, lsb_first, cpol, cpha, spe, loop
    function automatic logic [31:0] ctrl_word(input logic [15:0] prescale,
                                              input logic [7:0] width,
                                              input logic [5:0] flags);
        return {prescale, width, 2'b00, flags};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp) else begin
            $display("FAILED %0t: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        int waited;
        wr_req.addr = addr;
        wr_req.data = data;
        wr_valid_i  = 1'b1;
        waited      = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!wr_ready_o && waited < 20);
        if (!wr_ready_o) begin
            $display("Write to 0x%02h was never accepted at %0t", addr, $time);
            errors++;
        end
        @(posedge clk);
        #2;
        wr_valid_i = 1'b0;
        if (!b_valid_o) begin
            $display("Write to 0x%02h got no response at %0t", addr, $time);
            errors++;
        end
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        int waited;
        rd_req.addr = addr;
        rd_valid_i  = 1'b1;
        waited      = 0;
        do begin
            @(posedge clk);
            #2;
            waited++;
        end while (!rd_ready_o && waited < 20);
        if (!rd_ready_o) begin
            $display("Read of 0x%02h was never accepted at %0t", addr, $time);
            errors++;
        end
        @(posedge clk);
        #2;
        rd_valid_i = 1'b0;
        data       = r_data_o;
        if (!r_valid_o) begin
            $display("Read of 0x%02h returned no data at %0t", addr, $time);
            errors++;
        end
    endtask

    task automatic wait_rx_ready();
        logic [31:0] status;
        int          polls;
        status = 32'h1;
        polls  = 0;
        while (status[0] && polls < 100) begin
            read_reg(`SPI_REG_STATUS, status);
            polls++;
        end
        if (status[0]) begin
            $display("No word arrived in the RX FIFO by %0t", $time);
            errors++;
        end
    endtask

    task automatic slave_load(input logic [31:0] word);
        slave_tx = word & width_mask(m_width);
        slave_rx = '0;
        edge_k   = 0;
        // CPHA 0 needs the first bit out before the leading edge
        if (!m_cpha) begin
            spi_miso_i = slave_tx[bit_pos(0)];
        end
        slave_on = 1'b1;
    endtask

    // Slave model shifts on one SCLK edge and captures MOSI on the other
    initial begin
        forever begin
            @(spi_sclk_o);
            if (slave_on && edge_k < m_width) begin
                assert (spi_ncs_o == ~sel_mask) else begin
                    $display("FAILED %0t: ncs 0x%h in transfer, expected 0x%h",
                             $time, spi_ncs_o, ~sel_mask);
                    errors++;
                end
                if (spi_sclk_o != m_cpol) begin
                    if (m_cpha) begin
                        #2;
                        spi_miso_i = slave_tx[bit_pos(edge_k)];
                    end else begin
                        slave_rx[bit_pos(edge_k)] = spi_mosi_o;
                    end
                end else begin
                    if (m_cpha) begin
                        slave_rx[bit_pos(edge_k)] = spi_mosi_o;
                    end
                    edge_k++;
                    if (!m_cpha && edge_k < m_width) begin
                        #2;
                        spi_miso_i = slave_tx[bit_pos(edge_k)];
                    end
                end
            end
        end
    end

    initial begin
        logic [31:0] rdata;
        logic [31:0] words [LOOP_WORDS];
        logic [31:0] word;
        int          width;
        logic        cpol;
        logic        cpha;
        logic        lsb;

        errors     = 0;
        rand_state = 32'ha019758f;
        sel_mask   = '0;
        spe_off    = 1'b0;
        slave_on   = 1'b0;
        m_cpol     = 1'b0;
        m_cpha     = 1'b0;
        m_lsb      = 1'b0;
        m_width    = 8;
        edge_k     = 0;
        slave_tx   = '0;
        slave_rx   = '0;
        reset_i    = 1'b1;
        wr_req     = '0;
        wr_valid_i = 1'b0;
        b_ready_i  = 1'b1;
        rd_req     = '0;
        rd_valid_i = 1'b0;
        r_ready_i  = 1'b1;
        spi_miso_i = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        reset_i = 1'b0;

        read_reg(`SPI_REG_ID, rdata);
        check_value("ID", rdata, 32'h294EC100);
        read_reg(`SPI_REG_CTRL, rdata);
        check_value("reset control", rdata, 32'h00040020);
        read_reg(`SPI_REG_STATUS, rdata);
        check_value("reset status", rdata, 32'h5);

        // Loopback with 8 bit words MSB first
        write_reg(`SPI_REG_CTRL, ctrl_word(16'd1, 8'd8, 6'b100011));
        for (int i = 0; i < LOOP_WORDS; i++) begin
            words[i] = next_rand();
            write_reg(`SPI_REG_TX, words[i]);
        end
        for (int i = 0; i < LOOP_WORDS; i++) begin
            wait_rx_ready();
            read_reg(`SPI_REG_RX, rdata);
            check_value("loopback RX", rdata, words[i] & width_mask(8));
        end
        read_reg(`SPI_REG_STATUS, rdata);
        check_value("status after loopback", rdata, 32'h5);

        // Select changes only while the bus is gated
        write_reg(`SPI_REG_CTRL, ctrl_word(16'd1, 8'd8, 6'b000000));
        write_reg(`SPI_REG_SS, 32'hA);
        sel_mask = active_select(4'b1010);

        for (int m = 0; m < NUM_MODES; m++) begin
            cpol    = m[0];
            cpha    = m[1];
            lsb     = m[2];
            width   = (m == NUM_MODES - 1) ? 32 : 5 + int'(next_rand() % 32'd28);
            m_cpol  = cpol;
            m_cpha  = cpha;
            m_lsb   = lsb;
            m_width = width;
            write_reg(`SPI_REG_CTRL, ctrl_word(16'd1, 8'(width), {1'b0, lsb, cpol, cpha, 2'b10}));
            check_value("idle SCLK", 32'(spi_sclk_o), 32'(cpol));
            word = next_rand();
            slave_load(next_rand());
            write_reg(`SPI_REG_TX, word);
            wait_rx_ready();
            read_reg(`SPI_REG_RX, rdata);
            check_value("RX from slave", rdata, slave_tx);
            check_value("MOSI word at slave", slave_rx, word & width_mask(width));
            check_value("SCLK periods", edge_k, width);
            check_value("ncs after transfer", 32'(spi_ncs_o), 32'hF);
            check_value("SCLK after transfer", 32'(spi_sclk_o), 32'(cpol));
            slave_on = 1'b0;
        end

        // Nothing may leave the block while disabled with mssa and cpol set
        write_reg(`SPI_REG_CTRL, ctrl_word(16'd1, 8'd8, 6'b101100));
        spe_off = 1'b1;
        write_reg(`SPI_REG_TX, next_rand());
        repeat (50) @(posedge clk);
        #2;
        read_reg(`SPI_REG_STATUS, rdata);
        check_value("status with word held", rdata, 32'h1);
        write_reg(`SPI_REG_CTRL, ctrl_word(16'd1, 8'd8, 6'b101100));
        read_reg(`SPI_REG_STATUS, rdata);
        check_value("status after control write", rdata, 32'h5);
        spe_off = 1'b0;

        write_reg(`SPI_REG_CTRL, ctrl_word(16'd9, 8'd16, 6'b011110));
        write_reg(`SPI_REG_RESET, `SPI_RESET_KEY);
        read_reg(`SPI_REG_CTRL, rdata);
        check_value("control after software reset", rdata, 32'h00040020);
        read_reg(`SPI_REG_SS, rdata);
        check_value("select after software reset", rdata, 32'hF);
        sel_mask = active_select(4'hF);

        repeat (4) @(posedge clk);
        $display("Checks finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+hw
hw/spi_pkg.sv
hw/spi_fifo.sv
hw/spi_regs.sv
hw/spi_engine.sv
hw/spi_axil_top.sv
dv/tb_spi.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_spi
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
